// File: build.f
+incdir+include
rtl/battle_pkg.sv
rtl/unit_squad.sv
rtl/battle_referee.sv
rtl/battle_engine.sv
tb/battle_chk.sv
tb/tb_battle_engine.sv

// File: Makefile
# Verilator build and run of the battle engine testbench

VERILATOR ?= verilator
TOP       ?= tb_battle_engine
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f build.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/battle_tests.svh
// ---------------------------------------------------------------------------
// single-unit model, index 0 enemy, index 1 army
// ---------------------------------------------------------------------------
int         m_alive [2];
int         m_type  [2];
int         m_x     [2];
int         m_hp    [2];
int         m_phase [2];
logic [1:0] m_state [2];
int         m_tower_e;
int         m_tower_a;

task automatic model_frame();
    int  du [2];
    int  ox [2];
    int  oa [2];
    int  dt_e;
    int  dt_a;
    int  rng;
    int  hit;
    bit  opp_in;
    bit  tower_in;
    for (int s = 0; s < 2; s++) begin
        ox[s] = m_x[s];
        oa[s] = m_alive[s];
        du[s] = 0;
    end
    dt_e = 0;
    dt_a = 0;
    for (int s = 0; s < 2; s++) begin
        if (m_alive[s] != 0) begin
            rng = int'(battle_pkg::unit_range[m_type[s]]);
            if (s == 0) begin  // enemy marches right
                opp_in   = (oa[1] != 0) && (ox[1] <= m_x[0] + rng);
                tower_in = (m_x[0] + rng >= int'(battle_pkg::tower_a_x));
            end else begin
                opp_in   = (oa[0] != 0) && (m_x[1] <= ox[0] + rng);
                tower_in = (m_x[1] <= int'(battle_pkg::tower_e_x) + rng);
            end
            case (m_state[s])
                battle_pkg::st_move: begin
                    if (opp_in || tower_in) begin
                        m_state[s] = battle_pkg::st_windup;
                        m_phase[s] = 0;
                    end else begin
                        m_x[s] += (s == 0) ? int'(battle_pkg::unit_speed[m_type[s]])
                                           : -int'(battle_pkg::unit_speed[m_type[s]]);
                    end
                end
                battle_pkg::st_strike: begin
                    if (opp_in)
                        du[s] += int'(battle_pkg::unit_atk[m_type[s]]);
                    else if (s == 0)
                        dt_a += int'(battle_pkg::unit_atk[m_type[s]]);
                    else
                        dt_e += int'(battle_pkg::unit_atk[m_type[s]]);
                    m_state[s] = battle_pkg::st_recover;
                    m_phase[s] = 0;
                end
                default: begin  // windup or recover
                    if (m_phase[s] == int'(battle_pkg::unit_cd[m_type[s]])) begin
                        m_state[s] = (m_state[s] == battle_pkg::st_windup) ?
                                     battle_pkg::st_strike : battle_pkg::st_move;
                        m_phase[s] = 0;
                    end else begin
                        m_phase[s]++;
                    end
                end
            endcase
        end
    end
    for (int s = 0; s < 2; s++) begin
        hit = du[1 - s];
        if (m_alive[s] != 0) begin
            if (hit >= m_hp[s])
                m_alive[s] = 0;
            else
                m_hp[s] -= hit;
        end
    end
    m_tower_a = (dt_a >= m_tower_a) ? 0 : m_tower_a - dt_a;
    m_tower_e = (dt_e >= m_tower_e) ? 0 : m_tower_e - dt_e;
endtask

task automatic check_model(input string name);
    check({name, " enemy_count"}, m_alive[0], int'(enemy_count));
    check({name, " army_count"}, m_alive[1], int'(army_count));
    check({name, " enemy_front_x"}, (m_alive[0] != 0) ? m_x[0] :
          int'(battle_pkg::enemy_spawn_x), int'(enemy_front_x));
    check({name, " army_front_x"}, (m_alive[1] != 0) ? m_x[1] :
          int'(battle_pkg::army_spawn_x), int'(army_front_x));
    check({name, " tower_hp_enemy"}, m_tower_e, int'(tower_hp_enemy));
    check({name, " tower_hp_army"}, m_tower_a, int'(tower_hp_army));
endtask

// ---------------------------------------------------------------------------
// bus actions, entered and left 2 ns after a rising edge
// ---------------------------------------------------------------------------
task automatic new_game();
    @(posedge clk_25MHz);
    #2 start = 1'b1;
    @(posedge clk_25MHz);
    #2 start = 1'b0;
    m_alive   = '{0, 0};
    m_tower_e = int'(battle_pkg::tower_hp_init);
    m_tower_a = int'(battle_pkg::tower_hp_init);
endtask

task automatic spawn(input int side, input int t);
    spawn_valid = 1'b1;
    spawn_enemy = (side == 0);
    spawn_type  = t[battle_pkg::type_w-1:0];
    #1;
    while (!spawn_ready) begin
        @(posedge clk_25MHz);
        #3;
    end
    @(posedge clk_25MHz);
    #2 spawn_valid = 1'b0;
    @(posedge clk_25MHz);  // slot written here
    #2;
    m_alive[side] = 1;
    m_type[side]  = t;
    m_x[side]     = (side == 0) ? int'(battle_pkg::enemy_spawn_x) : int'(battle_pkg::army_spawn_x);
    m_hp[side]    = int'(battle_pkg::unit_hp[t]);
    m_state[side] = battle_pkg::st_move;
    m_phase[side] = 0;
endtask

task automatic do_frame();
    frame_valid = 1'b1;
    #1;
    while (!frame_ready) begin
        @(posedge clk_25MHz);
        #3;
    end
    @(posedge clk_25MHz);
    #2 frame_valid = 1'b0;
    @(posedge clk_25MHz);
    #2;
    while (!frame_ready && !game_win && !game_lose) begin
        @(posedge clk_25MHz);
        #2;
    end
    model_frame();
endtask

// ---------------------------------------------------------------------------
// directed tests
// ---------------------------------------------------------------------------
task automatic test_start();
    int e0;
    e0 = errors;
    new_game();
    check_model("start");
    check("start frame_ready", 1, int'(frame_ready));
    end_test("start", e0);
endtask

task automatic test_march();
    int e0;
    int t;
    e0 = errors;
    t  = rand_bits(2);
    new_game();
    spawn(1, t);
    repeat (10) do_frame();
    check("march army_front_x", int'(battle_pkg::army_spawn_x) -
          10 * int'(battle_pkg::unit_speed[t]), int'(army_front_x));
    check_model("march");
    end_test("march", e0);
endtask

task automatic test_slot_limit();
    int e0;
    e0 = errors;
    new_game();
    repeat (8) spawn(0, rand_bits(2));
    check("slots enemy_count", 8, int'(enemy_count));
    spawn_valid = 1'b1;
    spawn_enemy = 1'b1;
    repeat (3) begin
        #1 check("slots spawn_ready", 0, int'(spawn_ready));
        @(posedge clk_25MHz);
        #2;
    end
    check("slots enemy_count", 8, int'(enemy_count));
    spawn(1, rand_bits(2));
    check("slots army_count", 1, int'(army_count));
    end_test("slots", e0);
endtask

task automatic test_siege();
    int e0;
    e0 = errors;
    new_game();
    spawn(0, rand_bits(2));
    repeat (320) begin
        do_frame();
        check_model("siege");
    end
    end_test("siege", e0);
endtask

task automatic test_duel();
    int e0;
    int n;
    e0 = errors;
    n  = 0;
    new_game();
    spawn(0, rand_bits(2));
    spawn(1, rand_bits(2));
    while (m_alive[0] != 0 && m_alive[1] != 0 && n < 400) begin
        do_frame();
        check_model("duel");
        n++;
    end
    if (n == 400) begin
        errors++;
        $display("duel: neither unit died within 400 frames");
    end
    end_test("duel", e0);
endtask

task automatic test_game_end();
    int e0;
    int n;
    e0 = errors;
    n  = 0;
    new_game();
    spawn(0, rand_bits(2));
    while (m_tower_a > 0 && n < 700) begin
        do_frame();
        check_model("end");
        n++;
    end
    if (n == 700) begin
        errors++;
        $display("end: the army tower still stands after 700 frames");
    end
    check("end game_lose", 1, int'(game_lose));
    check("end game_win", 0, int'(game_win));
    spawn_enemy = 1'b0;
    repeat (4) begin
        @(posedge clk_25MHz);
        #3;
        check("end frame_ready", 0, int'(frame_ready));
        check("end spawn_ready", 0, int'(spawn_ready));
    end
    new_game();
    check_model("restart");
    check("restart frame_ready", 1, int'(frame_ready));
    end_test("game_end", e0);
endtask

// File: tb/tb_battle_engine.sv
`timescale 1ns/1ps

module tb_battle_engine;

    localparam int clk_period   = 40;
    localparam int frame_budget = 10 + 320 + 400 + 700;  // march, siege, duel cap, end cap
    localparam int timeout_cyc  = frame_budget * 11 + 6000;

    logic                          clk_25MHz;
    logic                          rst;
    logic                          start;
    logic                          frame_valid;
    logic                          frame_ready;
    logic                          spawn_valid;
    logic                          spawn_ready;
    logic                          spawn_enemy;
    logic [battle_pkg::type_w-1:0] spawn_type;
    logic [battle_pkg::hp_w-1:0]   tower_hp_enemy;
    logic [battle_pkg::hp_w-1:0]   tower_hp_army;
    logic [battle_pkg::slot_w:0]   enemy_count;
    logic [battle_pkg::slot_w:0]   army_count;
    logic [battle_pkg::x_w-1:0]    enemy_front_x;
    logic [battle_pkg::x_w-1:0]    army_front_x;
    logic                          game_win;
    logic                          game_lose;

    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    logic [31:0] lfsr_q = 32'hc2f5_d397;

    battle_engine dut (.*);

    always #(clk_period / 2) clk_25MHz = ~clk_25MHz;

    `include "battle_tests.svh"

    // galois form, one step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before)
            $display("%-10s ok", name);
        else
            $display("%-10s %0d errors", name, errors - errs_before);
    endtask

    initial begin
        clk_25MHz   = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        frame_valid = 1'b0;
        spawn_valid = 1'b0;
        spawn_enemy = 1'b0;
        spawn_type  = '0;
        repeat (5) @(posedge clk_25MHz);
        #2 rst = 1'b0;

        test_start();
        test_march();
        test_slot_limit();
        test_siege();
        test_duel();
        test_game_end();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, dut.u_ref.chk.fail_count);
        if (errors == 0 && dut.u_ref.chk.fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        repeat (timeout_cyc) @(posedge clk_25MHz);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cyc);
        $display("sim failed");
        $finish;
    end

endmodule

// File: tb/battle_chk.sv
`timescale 1ns/1ps

module battle_chk (
    input logic clk_25MHz,
    input logic rst,
    input logic start,
    input logic frame_valid,
    input logic frame_ready,
    input logic spawn_ready,
    input logic step,
    input logic game_win,
    input logic game_lose
);

    int         fail_count = 0;  // read by the testbench
    logic [3:0] frame_left;      // cycles left in the accepted frame

    always_ff @(posedge clk_25MHz) begin
        if (rst || start)
            frame_left <= '0;
        else if (frame_valid && frame_ready)
            frame_left <= 4'd11;
        else if (frame_left != '0)
            frame_left <= frame_left - 4'd1;
    end

    ready_in_frame: assert property (@(posedge clk_25MHz) disable iff (rst)
        (frame_left != '0) |-> (!frame_ready && !spawn_ready))
        else begin
            $error("ready high during a frame");
            fail_count++;
        end

    one_result: assert property (@(posedge clk_25MHz) disable iff (rst) !(game_win && game_lose))
        else begin
            $error("win and lose both high");
            fail_count++;
        end

    step_pulse: assert property (@(posedge clk_25MHz) disable iff (rst) step |=> !step)
        else begin
            $error("step longer than one cycle");
            fail_count++;
        end

endmodule

bind battle_referee battle_chk chk (
    .clk_25MHz(clk_25MHz), .rst(rst), .start(start), .frame_valid(frame_valid),
    .frame_ready(frame_ready), .spawn_ready(spawn_ready), .step(step),
    .game_win(game_win), .game_lose(game_lose)
);

// File: rtl/battle_engine.sv
`timescale 1ns/1ps

module battle_engine (
    input  logic                          clk_25MHz,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          frame_valid,
    output logic                          frame_ready,
    input  logic                          spawn_valid,
    output logic                          spawn_ready,
    input  logic                          spawn_enemy,
    input  logic [battle_pkg::type_w-1:0] spawn_type,
    output logic [battle_pkg::hp_w-1:0]   tower_hp_enemy,
    output logic [battle_pkg::hp_w-1:0]   tower_hp_army,
    output logic [battle_pkg::slot_w:0]   enemy_count,
    output logic [battle_pkg::slot_w:0]   army_count,
    output logic [battle_pkg::x_w-1:0]    enemy_front_x,
    output logic [battle_pkg::x_w-1:0]    army_front_x,
    output logic                          game_win,
    output logic                          game_lose
);

    logic                        spawn_go_e;
    logic                        spawn_go_a;
    logic                        step;
    logic                        hit_valid;
    logic [battle_pkg::hp_w-1:0] hit_amount_e;
    logic [battle_pkg::hp_w-1:0] hit_amount_a;
    logic                        has_free_e;
    logic                        has_free_a;
    logic                        enemy_front_alive;
    logic                        army_front_alive;
    logic [battle_pkg::hp_w-1:0] dmg_unit_e;
    logic [battle_pkg::hp_w-1:0] dmg_tower_e;
    logic [battle_pkg::hp_w-1:0] dmg_unit_a;
    logic [battle_pkg::hp_w-1:0] dmg_tower_a;
    logic                        scan_done;

    unit_squad #(.side_enemy(1'b1)) u_enemy (
        .clk_25MHz(clk_25MHz), .rst(rst), .start(start),
        .spawn_go(spawn_go_e), .spawn_type(spawn_type), .step(step),
        .opp_front_alive(army_front_alive), .opp_front_x(army_front_x),
        .hit_valid(hit_valid), .hit_amount(hit_amount_e),
        .has_free(has_free_e), .alive_count(enemy_count),
        .front_alive(enemy_front_alive), .front_x(enemy_front_x),
        .dmg_unit(dmg_unit_e), .dmg_tower(dmg_tower_e),
        .scan_done(scan_done)
    );

    // same scan timing as u_enemy
    unit_squad #(.side_enemy(1'b0)) u_army (
        .clk_25MHz(clk_25MHz), .rst(rst), .start(start),
        .spawn_go(spawn_go_a), .spawn_type(spawn_type), .step(step),
        .opp_front_alive(enemy_front_alive), .opp_front_x(enemy_front_x),
        .hit_valid(hit_valid), .hit_amount(hit_amount_a),
        .has_free(has_free_a), .alive_count(army_count),
        .front_alive(army_front_alive), .front_x(army_front_x),
        .dmg_unit(dmg_unit_a), .dmg_tower(dmg_tower_a),
        .scan_done()
    );

    battle_referee u_ref (
        .clk_25MHz(clk_25MHz), .rst(rst), .start(start),
        .frame_valid(frame_valid), .spawn_valid(spawn_valid), .spawn_enemy(spawn_enemy),
        .has_free_e(has_free_e), .has_free_a(has_free_a), .scan_done(scan_done),
        .dmg_unit_e(dmg_unit_e), .dmg_tower_e(dmg_tower_e),
        .dmg_unit_a(dmg_unit_a), .dmg_tower_a(dmg_tower_a),
        .frame_ready(frame_ready), .spawn_ready(spawn_ready),
        .spawn_go_e(spawn_go_e), .spawn_go_a(spawn_go_a), .step(step),
        .hit_valid(hit_valid), .hit_amount_e(hit_amount_e), .hit_amount_a(hit_amount_a),
        .tower_hp_enemy(tower_hp_enemy), .tower_hp_army(tower_hp_army),
        .game_win(game_win), .game_lose(game_lose)
    );

endmodule

// File: rtl/battle_referee.sv
`timescale 1ns/1ps

module battle_referee (
    input  logic                        clk_25MHz,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        frame_valid,
    input  logic                        spawn_valid,
    input  logic                        spawn_enemy,
    input  logic                        has_free_e,
    input  logic                        has_free_a,
    input  logic                        scan_done,
    input  logic [battle_pkg::hp_w-1:0] dmg_unit_e,
    input  logic [battle_pkg::hp_w-1:0] dmg_tower_e,
    input  logic [battle_pkg::hp_w-1:0] dmg_unit_a,
    input  logic [battle_pkg::hp_w-1:0] dmg_tower_a,
    output logic                        frame_ready,
    output logic                        spawn_ready,
    output logic                        spawn_go_e,
    output logic                        spawn_go_a,
    output logic                        step,
    output logic                        hit_valid,
    output logic [battle_pkg::hp_w-1:0] hit_amount_e,
    output logic [battle_pkg::hp_w-1:0] hit_amount_a,
    output logic [battle_pkg::hp_w-1:0] tower_hp_enemy,
    output logic [battle_pkg::hp_w-1:0] tower_hp_army,
    output logic                        game_win,
    output logic                        game_lose
);

    logic [1:0] phase;
    logic       frame_go;
    logic       spawn_go;

    assign frame_ready = (phase == battle_pkg::ph_idle);
    // a pending spawn has not yet taken its slot
    assign spawn_ready = frame_ready && !spawn_go_e && !spawn_go_a &&
                         (spawn_enemy ? has_free_e : has_free_a);
    assign frame_go = frame_valid && frame_ready;
    assign spawn_go = spawn_valid && spawn_ready;

    // ------------------------------------------------------------------------
    // frame sequencing, towers and result
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            phase          <= battle_pkg::ph_over;
            step           <= 1'b0;
            hit_valid      <= 1'b0;
            spawn_go_e     <= 1'b0;
            spawn_go_a     <= 1'b0;
            game_win       <= 1'b0;
            game_lose      <= 1'b0;
            tower_hp_enemy <= '0;
            tower_hp_army  <= '0;
        end else if (start) begin
            phase          <= battle_pkg::ph_idle;
            step           <= 1'b0;
            hit_valid      <= 1'b0;
            spawn_go_e     <= 1'b0;
            spawn_go_a     <= 1'b0;
            game_win       <= 1'b0;
            game_lose      <= 1'b0;
            tower_hp_enemy <= battle_pkg::tower_hp_init;
            tower_hp_army  <= battle_pkg::tower_hp_init;
        end else begin
            step       <= frame_go;
            spawn_go_e <= spawn_go && spawn_enemy;
            spawn_go_a <= spawn_go && !spawn_enemy;
            hit_valid  <= 1'b0;
            case (phase)
                battle_pkg::ph_idle: begin
                    if (frame_go)
                        phase <= battle_pkg::ph_scan;
                end
                battle_pkg::ph_scan: begin
                    if (scan_done) begin
                        phase     <= battle_pkg::ph_resolve;
                        hit_valid <= 1'b1;
                        // enemy strikes land on the army tower and vice versa
                        tower_hp_army  <= (dmg_tower_e >= tower_hp_army) ? '0 :
                                          tower_hp_army - dmg_tower_e;
                        tower_hp_enemy <= (dmg_tower_a >= tower_hp_enemy) ? '0 :
                                          tower_hp_enemy - dmg_tower_a;
                    end
                end
                battle_pkg::ph_resolve: begin
                    if (!hit_valid) begin
                        phase <= battle_pkg::ph_idle;
                    end else if (tower_hp_army == '0) begin  // own tower first
                        game_lose <= 1'b1;
                        phase     <= battle_pkg::ph_over;
                    end else if (tower_hp_enemy == '0) begin
                        game_win <= 1'b1;
                        phase    <= battle_pkg::ph_over;
                    end
                end
                default: ;  // waits for start
            endcase
        end
    end

    // unit damage crosses over to the other squad
    always_ff @(posedge clk_25MHz) begin
        if (phase == battle_pkg::ph_scan && scan_done) begin
            hit_amount_e <= dmg_unit_a;
            hit_amount_a <= dmg_unit_e;
        end
    end

endmodule

// File: rtl/unit_squad.sv
`timescale 1ns/1ps

module unit_squad #(
    parameter bit side_enemy = 1'b1
) (
    input  logic                          clk_25MHz,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          spawn_go,
    input  logic [battle_pkg::type_w-1:0] spawn_type,
    input  logic                          step,
    input  logic                          opp_front_alive,
    input  logic [battle_pkg::x_w-1:0]    opp_front_x,
    input  logic                          hit_valid,
    input  logic [battle_pkg::hp_w-1:0]   hit_amount,
    output logic                          has_free,
    output logic [battle_pkg::slot_w:0]   alive_count,
    output logic                          front_alive,
    output logic [battle_pkg::x_w-1:0]    front_x,
    output logic [battle_pkg::hp_w-1:0]   dmg_unit,
    output logic [battle_pkg::hp_w-1:0]   dmg_tower,
    output logic                          scan_done
);

    // per-slot fields
    logic [battle_pkg::slot_cnt-1:0] alive_q;
    logic [battle_pkg::type_w-1:0]   type_q  [battle_pkg::slot_cnt];
    logic [battle_pkg::x_w-1:0]      x_q     [battle_pkg::slot_cnt];
    logic [battle_pkg::hp_w-1:0]     hp_q    [battle_pkg::slot_cnt];
    logic [battle_pkg::state_w-1:0]  state_q [battle_pkg::slot_cnt];
    logic [3:0]                      phase_q [battle_pkg::slot_cnt];

    logic [battle_pkg::type_w-1:0] spawn_type_q;
    logic [battle_pkg::slot_w-1:0] free_idx;
    logic [battle_pkg::slot_w-1:0] front_idx;
    logic [battle_pkg::slot_w-1:0] scan_idx;
    logic                          scanning;
    logic                          opp_alive_q;
    logic [battle_pkg::x_w-1:0]    opp_x_q;
    logic [battle_pkg::hp_w-1:0]   unit_acc;
    logic [battle_pkg::hp_w-1:0]   tower_acc;

    // slot under scan
    logic [battle_pkg::type_w-1:0] cur_type;
    logic [battle_pkg::x_w-1:0]    cur_x;
    logic [battle_pkg::x_w-1:0]    move_x;
    logic [battle_pkg::hp_w-1:0]   cur_atk;
    logic [3:0]                    cur_cd;
    logic [4:0]                    cur_speed;
    logic [7:0]                    cur_range;
    logic                          visit;
    logic                          phase_end;
    logic                          strike_now;
    logic                          opp_in;
    logic                          tower_in;
    logic                          hit_kill;

    assign cur_type  = type_q[scan_idx];
    assign cur_x     = x_q[scan_idx];
    assign cur_atk   = battle_pkg::unit_atk[cur_type];
    assign cur_cd    = battle_pkg::unit_cd[cur_type];
    assign cur_speed = battle_pkg::unit_speed[cur_type];
    assign cur_range = battle_pkg::unit_range[cur_type];

    assign visit      = scanning && alive_q[scan_idx];
    assign phase_end  = (phase_q[scan_idx] == cur_cd);
    assign strike_now = visit && (state_q[scan_idx] == battle_pkg::st_strike);
    assign move_x     = side_enemy ? cur_x + {5'd0, cur_speed} : cur_x - {5'd0, cur_speed};

    assign scan_done = scanning && (&scan_idx);  // slot 7 visit
    assign has_free  = ~&alive_q;
    assign hit_kill  = (hit_amount >= hp_q[front_idx]);

    // strike of the slot under scan is already in the sums
    assign dmg_unit  = unit_acc + ((strike_now && opp_in) ? cur_atk : '0);
    assign dmg_tower = tower_acc + ((strike_now && !opp_in) ? cur_atk : '0);

    always_comb begin
        if (side_enemy) begin  // marching right
            opp_in   = opp_alive_q && ({1'b0, opp_x_q} <= {1'b0, cur_x} + {3'd0, cur_range});
            tower_in = ({1'b0, cur_x} + {3'd0, cur_range} >= {1'b0, battle_pkg::tower_a_x});
        end else begin
            opp_in   = opp_alive_q && ({1'b0, cur_x} <= {1'b0, opp_x_q} + {3'd0, cur_range});
            tower_in = ({1'b0, cur_x} <= {1'b0, battle_pkg::tower_e_x} + {3'd0, cur_range});
        end
    end

    // ------------------------------------------------------------------------
    // front unit, lowest free slot, head count
    // ------------------------------------------------------------------------
    always_comb begin
        front_alive = 1'b0;
        front_x     = side_enemy ? battle_pkg::enemy_spawn_x : battle_pkg::army_spawn_x;
        front_idx   = '0;
        free_idx    = '0;
        alive_count = '0;
        for (int i = battle_pkg::slot_cnt - 1; i >= 0; i--) begin
            if (!alive_q[i])
                free_idx = i[battle_pkg::slot_w-1:0];
        end
        for (int i = 0; i < battle_pkg::slot_cnt; i++) begin
            if (alive_q[i]) begin
                alive_count = alive_count + 1'b1;
                if (!front_alive || (side_enemy ? x_q[i] > front_x : x_q[i] < front_x)) begin
                    front_alive = 1'b1;
                    front_x     = x_q[i];
                    front_idx   = i[battle_pkg::slot_w-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            scanning <= 1'b0;
            scan_idx <= '0;
        end else if (step) begin
            scanning <= 1'b1;
            scan_idx <= '0;
        end else if (scanning) begin
            scan_idx <= scan_idx + 1'b1;
            if (scan_done)
                scanning <= 1'b0;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            alive_q <= '0;
        end else begin
            if (spawn_go)
                alive_q[free_idx] <= 1'b1;
            if (hit_valid && front_alive && hit_kill)
                alive_q[front_idx] <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // slot payload, opponent snapshot and damage sums
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_25MHz) begin
        spawn_type_q <= spawn_type;  // type held at the transfer edge
        if (step) begin
            opp_alive_q <= opp_front_alive;
            opp_x_q     <= opp_front_x;
            unit_acc    <= '0;
            tower_acc   <= '0;
        end else if (scanning) begin
            unit_acc  <= dmg_unit;
            tower_acc <= dmg_tower;
        end

        if (spawn_go) begin
            type_q[free_idx]  <= spawn_type_q;
            x_q[free_idx]     <= side_enemy ? battle_pkg::enemy_spawn_x : battle_pkg::army_spawn_x;
            hp_q[free_idx]    <= battle_pkg::unit_hp[spawn_type_q];
            state_q[free_idx] <= battle_pkg::st_move;
            phase_q[free_idx] <= '0;
        end

        if (visit) begin
            case (state_q[scan_idx])
                battle_pkg::st_move: begin
                    if (opp_in || tower_in) begin
                        state_q[scan_idx] <= battle_pkg::st_windup;
                        phase_q[scan_idx] <= '0;
                    end else begin
                        x_q[scan_idx] <= move_x;
                    end
                end
                battle_pkg::st_windup, battle_pkg::st_recover: begin
                    if (phase_end) begin
                        state_q[scan_idx] <= (state_q[scan_idx] == battle_pkg::st_windup) ?
                                             battle_pkg::st_strike : battle_pkg::st_move;
                        phase_q[scan_idx] <= '0;
                    end else begin
                        phase_q[scan_idx] <= phase_q[scan_idx] + 4'd1;
                    end
                end
                battle_pkg::st_strike: begin  // damage counted in the sums above
                    state_q[scan_idx] <= battle_pkg::st_recover;
                    phase_q[scan_idx] <= '0;
                end
            endcase
        end

        if (hit_valid && front_alive && !hit_kill)
            hp_q[front_idx] <= hp_q[front_idx] - hit_amount;
    end

endmodule

// File: rtl/battle_pkg.sv
package battle_pkg;

    // ------------------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------------------
    localparam int x_w      = 10;
    localparam int hp_w     = 12;
    localparam int slot_cnt = 8;
    localparam int slot_w   = 3;
    localparam int type_w   = 2;
    localparam int state_w  = 2;

    // unit states
    localparam logic [state_w-1:0] st_move    = 2'd0;
    localparam logic [state_w-1:0] st_windup  = 2'd1;
    localparam logic [state_w-1:0] st_strike  = 2'd2;
    localparam logic [state_w-1:0] st_recover = 2'd3;

    // referee phases
    localparam logic [1:0] ph_idle    = 2'd0;
    localparam logic [1:0] ph_scan    = 2'd1;
    localparam logic [1:0] ph_resolve = 2'd2;
    localparam logic [1:0] ph_over    = 2'd3;  // no game running

    // ------------------------------------------------------------------------
    // field coordinates and towers
    // ------------------------------------------------------------------------
    localparam logic [x_w-1:0]  enemy_spawn_x = 10'd10;
    localparam logic [x_w-1:0]  army_spawn_x  = 10'd570;
    localparam logic [x_w-1:0]  tower_e_x     = 10'd70;   // left tower
    localparam logic [x_w-1:0]  tower_a_x     = 10'd570;  // right tower
    localparam logic [hp_w-1:0] tower_hp_init = 12'd4000;

    // ------------------------------------------------------------------------
    // stats per type, shared by both sides
    // ------------------------------------------------------------------------
    // killer bird, white bear, metal duck, black bear
    localparam logic [hp_w-1:0] unit_hp    [4] = '{12'd300, 12'd800, 12'd500, 12'd1500};
    localparam logic [hp_w-1:0] unit_atk   [4] = '{12'd60, 12'd120, 12'd90, 12'd250};
    localparam logic [3:0]      unit_cd    [4] = '{4'd2, 4'd4, 4'd3, 4'd6};
    localparam logic [4:0]      unit_speed [4] = '{5'd6, 5'd3, 5'd4, 5'd2};
    localparam logic [7:0]      unit_range [4] = '{8'd40, 8'd20, 8'd100, 8'd25};

endpackage
